//--- rtl/clock_pkg.sv
package clock_pkg;

	//////////////////////////////////////////////////////////////////////
	// BCD field types
	//////////////////////////////////////////////////////////////////////

	// One decimal digit
	typedef logic [3:0] bcd_t;
	// Two decimal digits, e.g. seconds or month
	typedef logic [7:0] bcd2_t;
	// Four decimal digits, the year or the displayed digits
	typedef logic [15:0] bcd4_t;

	// Calendar time as it leaves the counter chain
	typedef struct packed {
		bcd2_t sec;
		bcd2_t min;
		bcd2_t hr;
		bcd2_t day;
		bcd2_t mon;
		bcd4_t year;
	} date_time_t;

	//////////////////////////////////////////////////////////////////////
	// Display and speed control
	//////////////////////////////////////////////////////////////////////

	typedef logic [2:0] disp_mode_t;
	typedef logic [1:0] speed_t;
	// Bit 0 is segment a, bit 6 is segment g, lit when high
	typedef logic [6:0] seg_t;

	localparam disp_mode_t MODE_MIN_SEC = 3'd0;
	localparam disp_mode_t MODE_HR_MIN  = 3'd1;
	localparam disp_mode_t MODE_MON_DAY = 3'd2;
	localparam disp_mode_t MODE_YEAR    = 3'd3;

	// Decodes to all segments off
	localparam bcd_t BLANK_DIGIT = 4'd15;

	// Cycles per second for each speed setting, index 0 is the fastest
	localparam int TICK_CNT_W = 6;
	localparam logic [3:0][TICK_CNT_W-1:0] TICK_DIV = {6'd50, 6'd8, 6'd3, 6'd1};

	// Scan step every 2**SCAN_DIV_W cycles
	localparam int SCAN_DIV_W = 2;

	//////////////////////////////////////////////////////////////////////
	// Field limits and start values
	//////////////////////////////////////////////////////////////////////

	localparam bcd2_t BCD2_ZERO  = 8'h00;
	localparam bcd2_t BCD2_ONE   = 8'h01;
	localparam bcd4_t BCD4_ZERO  = 16'h0000;
	localparam bcd2_t LIMIT_SEC  = 8'h59;
	localparam bcd2_t LIMIT_MIN  = 8'h59;
	localparam bcd2_t LIMIT_HR   = 8'h23;
	localparam bcd2_t LIMIT_MON  = 8'h12;
	localparam bcd4_t LIMIT_YEAR = 16'h9999;

	// 2000-01-01 00:00:00
	localparam date_time_t RESET_TIME = '{
		sec:  8'h00,
		min:  8'h00,
		hr:   8'h00,
		day:  8'h01,
		mon:  8'h01,
		year: 16'h2000
	};

endpackage

//--- rtl/tick_generator.sv
module tick_generator (
	input  logic              clk,
	input  logic              rst,
	input  clock_pkg::speed_t speed,
	input  logic              restart,
	output logic              sec_tick
);
	import clock_pkg::*;

	logic [TICK_CNT_W-1:0] div_cnt;
	logic [TICK_CNT_W-1:0] div_last;
	speed_t                speed_q;
	logic                  speed_chg;

	assign div_last  = TICK_DIV[speed] - TICK_CNT_W'(1);
	assign speed_chg = (speed != speed_q);

	// Last speed seen, so a new setting starts a fresh second
	always_ff @(posedge clk) begin
		speed_q <= speed;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			div_cnt  <= '0;
			sec_tick <= 1'b0;
		end else if (restart || speed_chg) begin
			div_cnt  <= '0;
			sec_tick <= 1'b0;
		end else if (div_cnt == div_last) begin
			// End of one second
			div_cnt  <= '0;
			sec_tick <= 1'b1;
		end else begin
			div_cnt  <= div_cnt + TICK_CNT_W'(1);
			sec_tick <= 1'b0;
		end
	end

endmodule

//--- rtl/bcd_counter.sv
module bcd_counter #(
	parameter int DIGITS = 2
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                inc,
	input  logic                load,
	input  logic [DIGITS*4-1:0] load_val,
	input  logic [DIGITS*4-1:0] limit,
	input  logic [DIGITS*4-1:0] first,
	input  logic [DIGITS*4-1:0] reset_val,
	output logic [DIGITS*4-1:0] cnt,
	output logic                carry
);
	import clock_pkg::*;

	logic [DIGITS*4-1:0] cnt_next;
	logic                at_limit;

	assign at_limit = (cnt == limit);
	// Combinational so the whole chain ripples in one cycle
	assign carry = inc && at_limit;

	// Decimal increment, digit 0 is the least significant
	always_comb begin : decimal_inc
		logic ripple;
		bcd_t digit;
		ripple = 1'b1;
		for (int i = 0; i < DIGITS; i++) begin
			digit = cnt[i*4 +: 4];
			if (!ripple) begin
				cnt_next[i*4 +: 4] = digit;
			end else if (digit == 4'd9) begin
				cnt_next[i*4 +: 4] = 4'd0;
			end else begin
				cnt_next[i*4 +: 4] = digit + 4'd1;
				ripple = 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= reset_val;
		end else if (load) begin
			cnt <= load_val;
		end else if (inc) begin
			// Wrap back to the first legal value
			cnt <= at_limit ? first : cnt_next;
		end
	end

endmodule

//--- rtl/month_length.sv
module month_length (
	input  clock_pkg::bcd2_t mon,
	input  clock_pkg::bcd4_t year,
	output clock_pkg::bcd2_t last_day
);
	import clock_pkg::*;

	logic century;
	logic leap;

	// Two-digit BCD value divisible by 4
	function automatic logic div_by_4(input bcd_t tens, input bcd_t ones);
		logic ok;
		if (tens[0]) begin
			ok = (ones == 4'd2) || (ones == 4'd6);
		end else begin
			ok = (ones == 4'd0) || (ones == 4'd4) || (ones == 4'd8);
		end
		return ok;
	endfunction

	// Year ends in 00
	assign century = (year[7:0] == 8'h00);

	// Every 4th year, except centuries not divisible by 400
	always_comb begin
		if (century) begin
			leap = div_by_4(year[15:12], year[11:8]);
		end else begin
			leap = div_by_4(year[7:4], year[3:0]);
		end
	end

	always_comb begin
		case (mon)
			8'h02: last_day = leap ? 8'h29 : 8'h28;
			8'h04,
			8'h06,
			8'h09,
			8'h11: last_day = 8'h30;
			default: last_day = 8'h31;
		endcase
	end

endmodule

//--- rtl/display_select.sv
module display_select (
	input  clock_pkg::disp_mode_t mode,
	input  clock_pkg::date_time_t now,
	output clock_pkg::bcd4_t      digits
);
	import clock_pkg::*;

	// Leftmost digit sits in the top nibble
	always_comb begin
		case (mode)
			MODE_MIN_SEC: begin
				digits = {now.min, now.sec};
			end
			MODE_HR_MIN: begin
				digits = {now.hr, now.min};
			end
			MODE_MON_DAY: begin
				digits = {now.mon, now.day};
			end
			MODE_YEAR: begin
				digits = now.year;
			end
			default: begin
				// Unused modes leave the display dark
				digits = {4{BLANK_DIGIT}};
			end
		endcase
	end

endmodule

//--- rtl/digit_scan.sv
module digit_scan (
	input  logic             clk,
	input  logic             rst,
	input  clock_pkg::bcd4_t digits,
	output logic [3:0]       an,
	output clock_pkg::seg_t  seg
);
	import clock_pkg::*;

	logic [SCAN_DIV_W-1:0] scan_div;
	logic [1:0]            scan_idx;
	logic                  scan_step;
	bcd_t                  cur_digit;

	//////////////////////////////////////////////////////////////////////
	// Segment decoder
	//////////////////////////////////////////////////////////////////////

	// Segment order is g f e d c b a, MSB first
	function automatic seg_t decode_seg(input bcd_t d);
		seg_t s;
		case (d)
			4'd0: s = 7'h3f;
			4'd1: s = 7'h06;
			4'd2: s = 7'h5b;
			4'd3: s = 7'h4f;
			4'd4: s = 7'h66;
			4'd5: s = 7'h6d;
			4'd6: s = 7'h7d;
			4'd7: s = 7'h07;
			4'd8: s = 7'h7f;
			4'd9: s = 7'h6f;
			// Anything else stays dark
			default: s = 7'h00;
		endcase
		return s;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Scan timing
	//////////////////////////////////////////////////////////////////////

	assign scan_step = &scan_div;
	assign cur_digit = digits[{scan_idx, 2'b00} +: 4];

	// Leftmost digit first, then downwards
	always_ff @(posedge clk) begin
		if (rst) begin
			scan_div <= '0;
			scan_idx <= 2'd3;
		end else begin
			scan_div <= scan_div + 1'b1;
			if (scan_step) begin
				scan_idx <= scan_idx - 2'd1;
			end
		end
	end

	// Anode and segments move together
	always_ff @(posedge clk) begin
		if (rst) begin
			an  <= 4'b1000;
			seg <= '0;
		end else begin
			an  <= 4'b0001 << scan_idx;
			seg <= decode_seg(cur_digit);
		end
	end

endmodule

//--- rtl/electronic_clock.sv
module electronic_clock (
	input  logic                  clk,
	input  logic                  rst,
	input  clock_pkg::speed_t     speed,
	input  clock_pkg::disp_mode_t mode,
	input  logic                  set_en,
	input  clock_pkg::date_time_t set_time,
	output clock_pkg::date_time_t now,
	output logic [3:0]            an,
	output clock_pkg::seg_t       seg,
	output logic [2:0]            led
);
	import clock_pkg::*;

	logic  sec_tick;
	logic  sec_inc;
	logic  carry_sec, carry_min, carry_hr, carry_day, carry_mon;
	bcd2_t day_limit;
	bcd4_t disp_digits;

	tick_generator tick_gen (
		.clk      (clk),
		.rst      (rst),
		.speed    (speed),
		.restart  (set_en),
		.sec_tick (sec_tick)
	);

	// A load freezes counting for its cycle
	assign sec_inc = sec_tick && !set_en;

	//////////////////////////////////////////////////////////////////////
	// Carry chain, seconds up to year
	//////////////////////////////////////////////////////////////////////

	bcd_counter #(.DIGITS(2)) cnt_sec (
		.clk(clk), .rst(rst), .inc(sec_inc), .load(set_en),
		.load_val(set_time.sec), .limit(LIMIT_SEC), .first(BCD2_ZERO),
		.reset_val(RESET_TIME.sec), .cnt(now.sec), .carry(carry_sec)
	);

	bcd_counter #(.DIGITS(2)) cnt_min (
		.clk(clk), .rst(rst), .inc(carry_sec), .load(set_en),
		.load_val(set_time.min), .limit(LIMIT_MIN), .first(BCD2_ZERO),
		.reset_val(RESET_TIME.min), .cnt(now.min), .carry(carry_min)
	);

	bcd_counter #(.DIGITS(2)) cnt_hr (
		.clk(clk), .rst(rst), .inc(carry_min), .load(set_en),
		.load_val(set_time.hr), .limit(LIMIT_HR), .first(BCD2_ZERO),
		.reset_val(RESET_TIME.hr), .cnt(now.hr), .carry(carry_hr)
	);

	// Day limit follows the month and the leap year
	bcd_counter #(.DIGITS(2)) cnt_day (
		.clk(clk), .rst(rst), .inc(carry_hr), .load(set_en),
		.load_val(set_time.day), .limit(day_limit), .first(BCD2_ONE),
		.reset_val(RESET_TIME.day), .cnt(now.day), .carry(carry_day)
	);

	bcd_counter #(.DIGITS(2)) cnt_mon (
		.clk(clk), .rst(rst), .inc(carry_day), .load(set_en),
		.load_val(set_time.mon), .limit(LIMIT_MON), .first(BCD2_ONE),
		.reset_val(RESET_TIME.mon), .cnt(now.mon), .carry(carry_mon)
	);

	bcd_counter #(.DIGITS(4)) cnt_year (
		.clk(clk), .rst(rst), .inc(carry_mon), .load(set_en),
		.load_val(set_time.year), .limit(LIMIT_YEAR), .first(BCD4_ZERO),
		.reset_val(RESET_TIME.year), .cnt(now.year), .carry()
	);

	month_length mon_len (
		.mon      (now.mon),
		.year     (now.year),
		.last_day (day_limit)
	);

	//////////////////////////////////////////////////////////////////////
	// Display path
	//////////////////////////////////////////////////////////////////////

	display_select disp_sel (
		.mode   (mode),
		.now    (now),
		.digits (disp_digits)
	);

	digit_scan scan (
		.clk    (clk),
		.rst    (rst),
		.digits (disp_digits),
		.an     (an),
		.seg    (seg)
	);

	assign led = {carry_hr, carry_min, carry_sec};

endmodule

//--- dv/electronic_clock_properties.sv
module electronic_clock_properties (
	input  logic                  clk,
	input  logic                  rst,
	input  clock_pkg::speed_t     speed,
	input  clock_pkg::disp_mode_t mode,
	input  logic                  set_en,
	input  clock_pkg::date_time_t set_time,
	input  clock_pkg::date_time_t now,
	input  logic [3:0]            an,
	input  clock_pkg::seg_t       seg,
	input  logic [2:0]            led
);
	import clock_pkg::*;

	// Segments for digits 0 to 9 with bit 0 as segment a
	localparam seg_t SEG_TABLE [10] = '{
		7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07, 7'h7f, 7'h6f
	};

	int         fail_count = 0;
	int         gap;
	int         scan_cyc;
	logic       prev_rst, prev_set_en;
	logic [2:0] prev_led;
	speed_t     prev_speed;
	disp_mode_t prev_mode;
	date_time_t prev_now, prev_set_time;
	bcd4_t      exp_digits;
	seg_t       exp_seg;
	logic       changed;
	logic       steady;

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	function automatic int bcd_val(input bcd4_t b);
		return int'(b[15:12]) * 1000 + int'(b[11:8]) * 100 + int'(b[7:4]) * 10 + int'(b[3:0]);
	endfunction

	function automatic bcd4_t to_bcd(input int v);
		return {4'(v / 1000 % 10), 4'(v / 100 % 10), 4'(v / 10 % 10), 4'(v % 10)};
	endfunction

	function automatic int ref_last_day(input bcd2_t mon, input bcd4_t year);
		int   m, y;
		logic leap;
		m = bcd_val(16'(mon));
		y = bcd_val(year);
		leap = (y % 4 == 0 && y % 100 != 0) || (y % 400 == 0);
		if (m == 2) begin
			return leap ? 29 : 28;
		end
		return (m == 4 || m == 6 || m == 9 || m == 11) ? 30 : 31;
	endfunction

	// One second later with the carry rippling up to the year
	function automatic date_time_t successor(input date_time_t t);
		int s, mi, h, d, mo, y;
		s = bcd_val(16'(t.sec)) + 1;
		mi = bcd_val(16'(t.min));
		h = bcd_val(16'(t.hr));
		d = bcd_val(16'(t.day));
		mo = bcd_val(16'(t.mon));
		y = bcd_val(t.year);
		if (s == 60) begin
			s = 0;
			mi++;
		end
		if (mi == 60) begin
			mi = 0;
			h++;
		end
		if (h == 24) begin
			h = 0;
			d++;
		end
		if (d > ref_last_day(t.mon, t.year)) begin
			d = 1;
			mo++;
		end
		if (mo == 13) begin
			mo = 1;
			y++;
		end
		return '{sec: 8'(to_bcd(s)), min: 8'(to_bcd(mi)), hr: 8'(to_bcd(h)),
			day: 8'(to_bcd(d)), mon: 8'(to_bcd(mo)), year: to_bcd(y % 10000)};
	endfunction

	function automatic bcd4_t ref_digits(input disp_mode_t m, input date_time_t t);
		case (m)
			3'd0: return {t.min, t.sec};
			3'd1: return {t.hr, t.min};
			3'd2: return {t.mon, t.day};
			3'd3: return t.year;
			default: return 16'hffff;
		endcase
	endfunction

	function automatic seg_t ref_seg(input bcd_t d);
		return (d > 4'd9) ? 7'h00 : SEG_TABLE[d];
	endfunction

	task automatic note_failure(input string what);
		fail_count++;
		$error("Error at time %0t: %s", $time, what);
	endtask

	//////////////////////////////////////////////////////////////////////
	// History of the previous cycle
	//////////////////////////////////////////////////////////////////////

	assign changed = (now != prev_now);
	assign steady = !rst && !prev_rst && !prev_set_en;
	assign exp_digits = ref_digits(prev_mode, prev_now);

	always_comb begin
		exp_seg = '0;
		for (int i = 0; i < 4; i++) begin
			if (an[i]) begin
				exp_seg = ref_seg(exp_digits[i*4 +: 4]);
			end
		end
	end

	// Cycles since the last change of now
	// Negative right after a restart
	always_ff @(posedge clk) begin
		prev_rst <= rst;
		prev_set_en <= set_en;
		prev_set_time <= set_time;
		prev_now <= now;
		prev_led <= led;
		prev_mode <= mode;
		prev_speed <= speed;
		if (rst || set_en || speed != prev_speed) begin
			gap <= -1;
		end else if (changed && gap > 0) begin
			gap <= 1;
		end else begin
			gap <= gap + 1;
		end
	end

	// Cycles counted from the end of reset
	always_ff @(posedge clk) begin
		if (rst) begin
			scan_cyc <= 0;
		end else begin
			scan_cyc <= scan_cyc + 1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Assertions
	//////////////////////////////////////////////////////////////////////

	ap_reset: assert property (@(posedge clk) (prev_rst && !rst) |->
		(now == RESET_TIME && led == 3'b000 && an == 4'b1000))
		else note_failure("state after reset is wrong");
	ap_step: assert property (@(posedge clk) steady |->
		(now == prev_now || now == successor(prev_now)))
		else note_failure("now did not hold or advance by one second");
	ap_load: assert property (@(posedge clk) (!rst && !prev_rst && prev_set_en) |->
		(now == prev_set_time))
		else note_failure("load did not set now to set_time");
	ap_led: assert property (@(posedge clk) steady |-> (prev_led == {
		prev_now.hr == 8'h23 && now.hr == 8'h00,
		prev_now.min == 8'h59 && now.min == 8'h00,
		prev_now.sec == 8'h59 && now.sec == 8'h00}))
		else note_failure("led pulse does not match a field wrap");
	ap_day_wrap: assert property (@(posedge clk)
		(steady && now.day == 8'h01 && prev_now.day != 8'h01) |->
		(bcd_val(16'(prev_now.day)) == ref_last_day(prev_now.mon, prev_now.year)))
		else note_failure("day wrapped before the end of the month");
	ap_year_wrap: assert property (@(posedge clk)
		(steady && prev_now.year == 16'h9999 && now.year != 16'h9999) |->
		(now.year == 16'h0000))
		else note_failure("year 9999 did not wrap to 0000");
	ap_tick_gap: assert property (@(posedge clk)
		(steady && speed == prev_speed && gap > 0) |->
		(changed == (gap == int'(TICK_DIV[speed]))))
		else note_failure("now did not advance exactly every TICK_DIV cycles");
	ap_onehot: assert property (@(posedge clk) !rst |-> $onehot(an))
		else note_failure("anode select is not one-hot");
	ap_scan: assert property (@(posedge clk) (!rst && !prev_rst) |->
		(an == (4'b1000 >> ((scan_cyc - 1) / 4 % 4))))
		else note_failure("anode does not step from digit 3 down every 4 cycles");
	ap_seg: assert property (@(posedge clk) (!rst && !prev_rst) |-> (seg == exp_seg))
		else note_failure("segments do not match the selected digit");

endmodule

//--- dv/electronic_clock_tb.sv
module electronic_clock_tb;
	import clock_pkg::*;

	localparam int RESET_CYCLES = 2;
	localparam int FREE_RUN = 150;
	localparam int FIXED_LOADS = 5;
	localparam int RANDOM_LOADS = 8;
	localparam int LOAD_RUN = 14;
	localparam int SPEED_RUN = 250;
	localparam int MODE_RUN = 20;
	localparam int TEST_CYCLES = RESET_CYCLES + FREE_RUN
		+ (FIXED_LOADS + RANDOM_LOADS) * (LOAD_RUN + 2) + 3 * SPEED_RUN + 8 * MODE_RUN;
	localparam int CYCLE_LIMIT = TEST_CYCLES + TEST_CYCLES / 4 + 50;

	// February around the leap rule, then the very last day of 9999
	localparam bcd2_t FIX_MON [FIXED_LOADS] = '{8'h02, 8'h02, 8'h02, 8'h02, 8'h12};
	localparam bcd2_t FIX_DAY [FIXED_LOADS] = '{8'h28, 8'h29, 8'h28, 8'h29, 8'h31};
	localparam bcd4_t FIX_YEAR [FIXED_LOADS] = '{16'h2023, 16'h2024, 16'h2100, 16'h2400, 16'h9999};
	localparam bcd2_t MONTH_END [12] = '{
		8'h31, 8'h28, 8'h31, 8'h30, 8'h31, 8'h30, 8'h31, 8'h31, 8'h30, 8'h31, 8'h30, 8'h31
	};

	logic        clk;
	logic        rst;
	logic        set_en;
	speed_t      speed;
	disp_mode_t  mode;
	date_time_t  set_time, now;
	logic [3:0]  an;
	seg_t        seg;
	logic [2:0]  led;
	logic [31:0] lfsr;
	int          cycle = 0;
	int          fails;

	electronic_clock UUT (
		.clk(clk), .rst(rst), .speed(speed), .mode(mode), .set_en(set_en),
		.set_time(set_time), .now(now), .an(an), .seg(seg), .led(led)
	);

	bind electronic_clock electronic_clock_properties props (
		.clk(clk), .rst(rst), .speed(speed), .mode(mode), .set_en(set_en),
		.set_time(set_time), .now(now), .an(an), .seg(seg), .led(led)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= CYCLE_LIMIT) begin
			$display("Timeout: stimulus still running after %0d cycles", cycle);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	task automatic take_bits(input int n, output int val);
		val = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			val = (val << 1) | int'(lfsr[0]);
		end
	endtask

	task automatic random_digit(output bcd_t d);
		int v;
		take_bits(4, v);
		d = bcd_t'(v % 10);
	endtask

	task automatic run_cycles(input int n);
		repeat (n) @(posedge clk);
	endtask

	task automatic load_time(input date_time_t t);
		@(posedge clk);
		set_time <= t;
		set_en <= 1'b1;
		@(posedge clk);
		set_en <= 1'b0;
	endtask

	// 23:59:5x on a month end, then run past midnight
	task automatic load_month_end(input bcd2_t mon_v, input bcd2_t day_v, input bcd4_t year_v);
		bcd_t s;
		random_digit(s);
		load_time('{sec: {4'd5, s}, min: 8'h59, hr: 8'h23, day: day_v, mon: mon_v, year: year_v});
		run_cycles(LOAD_RUN);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		bcd4_t year;
		bcd_t  d;
		int    idx;
		rst <= 1'b1;
		speed <= '0;
		mode <= MODE_MIN_SEC;
		set_en <= 1'b0;
		set_time <= RESET_TIME;
		lfsr = 32'ha809;
		run_cycles(RESET_CYCLES);
		rst <= 1'b0;

		run_cycles(FREE_RUN);

		for (int i = 0; i < FIXED_LOADS; i++) begin
			load_month_end(FIX_MON[i], FIX_DAY[i], FIX_YEAR[i]);
		end
		// Random month ends, the first one a 30-day month
		for (int i = 0; i < RANDOM_LOADS; i++) begin
			take_bits(4, idx);
			idx = (i == 0) ? 3 : idx % 12;
			for (int k = 0; k < 4; k++) begin
				random_digit(d);
				year[k*4 +: 4] = d;
			end
			load_month_end({4'((idx + 1) / 10), 4'((idx + 1) % 10)}, MONTH_END[idx], year);
		end

		for (int s = 1; s < 4; s++) begin
			speed <= speed_t'(s);
			run_cycles(SPEED_RUN);
		end

		speed <= '0;
		for (int m = 0; m < 8; m++) begin
			mode <= disp_mode_t'(m);
			run_cycles(MODE_RUN);
		end
		run_cycles(2);

		fails = UUT.props.fail_count;
		$display("Run finished after %0d cycles with %0d assertion failures", cycle, fails);
		if (fails == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- all.f
rtl/clock_pkg.sv
rtl/tick_generator.sv
rtl/bcd_counter.sv
rtl/month_length.sv
rtl/display_select.sv
rtl/digit_scan.sv
rtl/electronic_clock.sv
dv/electronic_clock_properties.sv
dv/electronic_clock_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= electronic_clock_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
